/* riscv_testdata.txt */
# T name trap   | P addr instr | S addr data (hex)
T alu 0
P 00000000 00500093
P 00000004 FFD00113
P 00000008 002081B3
P 0000000C 40208233
P 00000010 0020C2B3
P 00000014 40115333
P 00000018 0020B3B3
P 0000001C 12345437
P 00000020 67846493
P 00000024 00409513
P 00000028 00012593
P 0000002C 00302023
P 00000030 00402223
P 00000034 00502423
P 00000038 00602623
P 0000003C 00702823
P 00000040 00902A23
P 00000044 00A02C23
P 00000048 00B02E23
P 0000004C 00000073
S 00000000 00000002
S 00000004 00000008
S 00000008 FFFFFFF8
S 0000000C FFFFFFFF
S 00000010 00000001
S 00000014 12345678
S 00000018 00000050
S 0000001C 00000001
T hazard_load 0
P 00000000 00700093
P 00000004 00108113
P 00000008 04202023
P 0000000C 04002183
P 00000010 00318233
P 00000014 04402223
P 00000018 00000073
S 00000040 00000008
S 00000044 00000010
T illegal 1
P 00000000 00300093
P 00000004 00102023
P 00000008 0000007F
P 0000000C 00102223
P 00000010 00000073
S 00000000 00000003

/* sources.f */
core_pkg.sv
isa_pkg.sv
pipe_ifs.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_wb_stage.sv
riscv_core.sv
tb_checker.sv
tb_riscv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
RTL_TOP   ?= riscv_core
FLIST     ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_riscv_core.sv */
// ****************************
// Testbench top: clock, reset,
// memory models, test sequence
// ****************************
module tb_riscv_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] ResetPc   = 32'h0000_0200;
  localparam int          MaxCycles = 2000;
  localparam logic [31:0] Nop       = 32'h0000_0013;  // addi x0, x0, 0

  logic        clk = 1'b0;
  logic        rst_n;
  logic        o_imem_valid;
  logic [31:0] o_imem_addr;
  logic        i_imem_ready;
  logic [31:0] i_imem_rdata;
  logic        o_dmem_valid;
  logic        o_dmem_we;
  logic [31:0] o_dmem_addr;
  logic [31:0] o_dmem_wdata;
  logic        i_dmem_ready;
  logic [31:0] i_dmem_rdata;
  logic        o_halted;
  logic        o_trap;

  int          seed = 77;
  logic [31:0] imem [logic [31:0]];
  logic [31:0] dmem [logic [31:0]];

  // Records from the data file
  string       names [$];
  logic        traps [$];
  byte         rec_kind [$];
  int          rec_test [$];
  logic [31:0] rec_a [$];
  logic [31:0] rec_d [$];

  always #50 clk = ~clk;

  riscv_core #(.RESET_PC(ResetPc)) dut0 (.*);

  tb_checker #(.RESET_PC(ResetPc)) chk0 (
    .clk(clk), .rst_n(rst_n),
    .i_imem_valid(o_imem_valid), .i_imem_addr(o_imem_addr), .i_imem_ready(i_imem_ready),
    .i_dmem_valid(o_dmem_valid), .i_dmem_we(o_dmem_we), .i_dmem_addr(o_dmem_addr),
    .i_dmem_wdata(o_dmem_wdata), .i_dmem_ready(i_dmem_ready),
    .i_halted(o_halted), .i_trap(o_trap)
  );

  // Random ready on both ports
  always @(negedge clk) begin
    i_imem_ready = ($random(seed) & 3) != 0;
    i_dmem_ready = ($random(seed) & 3) != 0;
    // Read data follows the held address
    i_imem_rdata = imem.exists(o_imem_addr) ? imem[o_imem_addr] : Nop;
    i_dmem_rdata = dmem.exists(o_dmem_addr) ? dmem[o_dmem_addr] : ~o_dmem_addr;
  end

  always @(posedge clk) begin
    if (rst_n && o_dmem_valid && o_dmem_we && i_dmem_ready) dmem[o_dmem_addr] = o_dmem_wdata;
  end

  task automatic read_testdata();
    int    fd;
    string line;
    string kind;
    string name;
    int    trap;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("riscv_testdata.txt", "r");
    if (fd == 0) $display("cannot open riscv_testdata.txt");
    while (fd != 0 && !$feof(fd)) begin
      if ($fgets(line, fd) == 0) continue;
      if ($sscanf(line, "%s", kind) < 1 || kind == "#") continue;
      if (kind == "T" && $sscanf(line, "%s %s %d", kind, name, trap) == 3) begin
        names.push_back(name);
        traps.push_back(trap != 0);
      end else if ($sscanf(line, "%s %h %h", kind, a, d) == 3 && names.size() > 0) begin
        rec_kind.push_back(kind == "P" ? "P" : "S");
        rec_test.push_back(names.size() - 1);
        rec_a.push_back(a);
        rec_d.push_back(d);
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  task automatic run_test(input int t);
    int cycles;
    @(negedge clk);
    rst_n = 1'b0;
    imem.delete();
    dmem.delete();
    chk0.begin_test(names[t], traps[t]);
    // Program addresses are offsets from the reset PC
    foreach (rec_kind[i]) begin
      if (rec_test[i] != t) continue;
      if (rec_kind[i] == "P") imem[ResetPc + rec_a[i]] = rec_d[i];
      else chk0.expect_store(rec_a[i], rec_d[i]);
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    cycles = 0;
    while (!o_halted && cycles < MaxCycles) begin
      @(negedge clk);
      cycles++;
    end
    // A few more cycles to catch requests after halt
    for (int i = 0; i < 10; i++) @(negedge clk);
    chk0.end_test(!o_halted);
  endtask

  initial begin
    rst_n        = 1'b0;
    i_imem_ready = 1'b0;
    i_imem_rdata = '0;
    i_dmem_ready = 1'b0;
    i_dmem_rdata = '0;
    read_testdata();
    if (names.size() == 0) $display("no tests found in the data file");
    for (int t = 0; t < names.size(); t++) run_test(t);
    chk0.print_summary();
    if (chk0.failed_tests() == 0 && names.size() > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_riscv_core

/* tb_checker.sv */
// ****************************
// Store stream, handshake and
// halt status checks per test
// ****************************
module tb_checker #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input logic        clk,
  input logic        rst_n,
  input logic        i_imem_valid,
  input logic [31:0] i_imem_addr,
  input logic        i_imem_ready,
  input logic        i_dmem_valid,
  input logic        i_dmem_we,
  input logic [31:0] i_dmem_addr,
  input logic [31:0] i_dmem_wdata,
  input logic        i_dmem_ready,
  input logic        i_halted,
  input logic        i_trap
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  string       test_name;
  logic        exp_trap;
  logic        active = 1'b0;
  logic        first_fetch;    // Next imem request is the first after reset
  logic        imem_wait;      // Open request from the last edge
  logic        dmem_wait;
  logic [31:0] imem_addr_q;
  logic [31:0] dmem_addr_q;
  logic [31:0] dmem_wdata_q;
  logic        dmem_we_q;
  int          errors;
  int          n_pass = 0;
  int          n_fail = 0;

  task automatic begin_test(input string name, input logic trap);
    test_name = name;
    exp_trap  = trap;
    exp_addr.delete();
    exp_data.delete();
    errors    = 0;
    active    = 1'b1;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("FAILED %s: %s expected %08h got %08h", test_name, sig, exp, got);
    errors++;
  endtask

  task automatic note_error(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  always @(posedge clk) begin
    if (active && !rst_n) begin
      if (i_imem_valid || i_dmem_valid || i_halted || i_trap)
        note_error("a port valid or status output is high during reset");
      first_fetch = 1'b1;
      imem_wait   = 1'b0;
      dmem_wait   = 1'b0;
    end else if (active) begin
      if (first_fetch && i_imem_valid) begin
        if (i_imem_addr !== RESET_PC) value_error("o_imem_addr", RESET_PC, i_imem_addr);
        first_fetch = 1'b0;
      end
      if (imem_wait && (!i_imem_valid || i_imem_addr !== imem_addr_q))
        value_error("o_imem_addr", imem_addr_q, i_imem_addr);
      if (dmem_wait && (!i_dmem_valid || i_dmem_addr !== dmem_addr_q))
        value_error("o_dmem_addr", dmem_addr_q, i_dmem_addr);
      if (dmem_wait && i_dmem_wdata !== dmem_wdata_q)
        value_error("o_dmem_wdata", dmem_wdata_q, i_dmem_wdata);
      if (dmem_wait && i_dmem_we !== dmem_we_q)
        value_error("o_dmem_we", 32'(dmem_we_q), 32'(i_dmem_we));
      if (i_halted && i_dmem_valid) note_error("data request raised after halt");
      if (i_halted && i_imem_valid && !imem_wait) note_error("fetch raised after halt");
      if (i_dmem_valid && i_dmem_we && i_dmem_ready) begin
        if (exp_addr.size() == 0) begin
          note_error($sformatf("unexpected store to %08h", i_dmem_addr));
        end else begin
          if (i_dmem_addr !== exp_addr[0]) value_error("o_dmem_addr", exp_addr[0], i_dmem_addr);
          if (i_dmem_wdata !== exp_data[0])
            value_error("o_dmem_wdata", exp_data[0], i_dmem_wdata);
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
        end
      end
      imem_wait    = i_imem_valid && !i_imem_ready;
      dmem_wait    = i_dmem_valid && !i_dmem_ready;
      imem_addr_q  = i_imem_addr;
      dmem_addr_q  = i_dmem_addr;
      dmem_wdata_q = i_dmem_wdata;
      dmem_we_q    = i_dmem_we;
    end
  end

  task automatic end_test(input logic timed_out);
    active = 1'b0;
    if (timed_out) note_error("core did not halt before the timeout");
    else if (i_trap !== exp_trap) value_error("o_trap", 32'(exp_trap), 32'(i_trap));
    if (exp_addr.size() != 0) note_error($sformatf("%0d expected stores never appeared",
                                                   exp_addr.size()));
    if (errors == 0) begin
      n_pass++;
      $display("test %s passed", test_name);
    end else begin
      n_fail++;
      $display("test %s failed with %0d errors", test_name, errors);
    end
  endtask

  task automatic print_summary();
    $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
  endtask

  function automatic int failed_tests();
    return n_fail;
  endfunction

endmodule : tb_checker

/* riscv_core.sv */
// ****************************
// Four stage RV32I core top
// ****************************
module riscv_core #(
  parameter logic [core_pkg::AddrWidth-1:0] RESET_PC = core_pkg::ResetPcDefault
) (
  input  logic                           clk,
  input  logic                           rst_n,
  output logic                           o_imem_valid,
  output logic [core_pkg::AddrWidth-1:0] o_imem_addr,
  input  logic                           i_imem_ready,
  input  logic [core_pkg::DataWidth-1:0] i_imem_rdata,
  output logic                           o_dmem_valid,
  output logic                           o_dmem_we,
  output logic [core_pkg::AddrWidth-1:0] o_dmem_addr,
  output logic [core_pkg::DataWidth-1:0] o_dmem_wdata,
  input  logic                           i_dmem_ready,
  input  logic [core_pkg::DataWidth-1:0] i_dmem_rdata,
  output logic                           o_halted,
  output logic                           o_trap
);

  logic [core_pkg::DataWidth-1:0]    instr;        // IF/ID
  logic                              instr_valid;
  logic                              hold;         // Decode hold or data stall
  logic [core_pkg::RegAddrWidth-1:0] rs_addr [2];
  logic [core_pkg::DataWidth-1:0]    rs_data [2];
  logic                              wr_en;
  logic [core_pkg::RegAddrWidth-1:0] wr_addr;
  logic [core_pkg::DataWidth-1:0]    wr_data;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();

  fetch_stage #(.RESET_PC(RESET_PC)) fetch_0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_stall      (hold),
    .i_halted     (o_halted),
    .o_imem_valid (o_imem_valid),
    .o_imem_addr  (o_imem_addr),
    .i_imem_ready (i_imem_ready),
    .i_imem_rdata (i_imem_rdata),
    .o_instr      (instr),
    .o_instr_valid(instr_valid)
  );

  decode_stage decode_0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_instr      (instr),
    .i_instr_valid(instr_valid),
    .o_rs_addr    (rs_addr),
    .i_rs_data    (rs_data),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .o_hold       (hold)
  );

  reg_file #(
    .NUM_READ_PORTS(2),
    .NUM_REGS      (core_pkg::NumRegs)
  ) reg_file_0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_rs_addr(rs_addr),
    .o_rs_data(rs_data),
    .i_wr_en  (wr_en),
    .i_wr_addr(wr_addr),
    .i_wr_data(wr_data)
  );

  execute_stage execute_0 (
    .clk   (clk),
    .rst_n (rst_n),
    .id_ex (id_ex),
    .ex_mem(ex_mem)
  );

  mem_wb_stage mem_wb_0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_mem      (ex_mem),
    .o_dmem_valid(o_dmem_valid),
    .o_dmem_we   (o_dmem_we),
    .o_dmem_addr (o_dmem_addr),
    .o_dmem_wdata(o_dmem_wdata),
    .i_dmem_ready(i_dmem_ready),
    .i_dmem_rdata(i_dmem_rdata),
    .o_wr_en     (wr_en),
    .o_wr_addr   (wr_addr),
    .o_wr_data   (wr_data),
    .o_halted    (o_halted),
    .o_trap      (o_trap)
  );

endmodule : riscv_core

/* mem_wb_stage.sv */
// ****************************
// Data access, writeback and
// halt/trap status
// ****************************
module mem_wb_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  ex_mem_if.consumer                        ex_mem,
  output logic                              o_dmem_valid,
  output logic                              o_dmem_we,
  output logic [core_pkg::AddrWidth-1:0]    o_dmem_addr,
  output logic [core_pkg::DataWidth-1:0]    o_dmem_wdata,
  input  logic                              i_dmem_ready,
  input  logic [core_pkg::DataWidth-1:0]    i_dmem_rdata,
  output logic                              o_wr_en,
  output logic [core_pkg::RegAddrWidth-1:0] o_wr_addr,
  output logic [core_pkg::DataWidth-1:0]    o_wr_data,
  output logic                              o_halted,
  output logic                              o_trap
);

  logic active;      // Entry here and core still running
  logic mem_access;
  logic is_load;

  assign active     = ex_mem.valid && !o_halted;
  assign mem_access = active && (ex_mem.lsu_op != isa_pkg::LSU_NONE);
  assign is_load    = (ex_mem.lsu_op == isa_pkg::LSU_LOAD);

  assign o_dmem_valid = mem_access;
  assign o_dmem_we    = (ex_mem.lsu_op == isa_pkg::LSU_STORE);
  assign o_dmem_addr  = ex_mem.result[core_pkg::AddrWidth-1:0];
  assign o_dmem_wdata = ex_mem.store_data;
  assign ex_mem.stall = mem_access && !i_dmem_ready;

  // Load data lands in the handshake cycle
  assign o_wr_en   = active && ex_mem.rd_we && !ex_mem.stall;
  assign o_wr_addr = ex_mem.rd_addr;
  assign o_wr_data = is_load ? i_dmem_rdata : ex_mem.result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_halted <= 1'b0;
      o_trap   <= 1'b0;
    end else if (active && (ex_mem.halt || ex_mem.trap)) begin
      o_halted <= 1'b1;
      o_trap   <= ex_mem.trap;
    end
  end

  // Request held unchanged until ready
  a_dmem_stable : assert property (@(posedge clk) disable iff (!rst_n)
    o_dmem_valid && !i_dmem_ready |=> o_dmem_valid && $stable(o_dmem_addr) &&
      $stable(o_dmem_we) && $stable(o_dmem_wdata));

endmodule : mem_wb_stage

/* execute_stage.sv */
// ****************************
// ALU and EX/MEM register
// ****************************
module execute_stage (
  input logic        clk,
  input logic        rst_n,
  id_ex_if.consumer  id_ex,
  ex_mem_if.producer ex_mem
);

  localparam int ShamtWidth = $clog2(core_pkg::DataWidth);

  logic [core_pkg::DataWidth-1:0] a;
  logic [core_pkg::DataWidth-1:0] b;
  logic [ShamtWidth-1:0]          shamt;
  logic [core_pkg::DataWidth-1:0] result;

  assign a     = id_ex.operand_a;
  assign b     = id_ex.operand_b;
  assign shamt = b[ShamtWidth-1:0];

  always_comb begin
    unique case (id_ex.alu_op)
      isa_pkg::ALU_ADD:  result = a + b;
      isa_pkg::ALU_SUB:  result = a - b;
      isa_pkg::ALU_AND:  result = a & b;
      isa_pkg::ALU_OR:   result = a | b;
      isa_pkg::ALU_XOR:  result = a ^ b;
      isa_pkg::ALU_SLL:  result = a << shamt;
      isa_pkg::ALU_SRL:  result = a >> shamt;
      isa_pkg::ALU_SRA:  result = core_pkg::DataWidth'($signed(a) >>> shamt);
      isa_pkg::ALU_SLT:  result = core_pkg::DataWidth'($signed(a) < $signed(b));
      isa_pkg::ALU_SLTU: result = core_pkg::DataWidth'(a < b);
      default:           result = b;  // LUI immediate
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else if (!ex_mem.stall) begin
      ex_mem.valid <= id_ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_mem.stall) begin
      ex_mem.result     <= result;
      ex_mem.store_data <= id_ex.store_data;
      ex_mem.lsu_op     <= id_ex.lsu_op;
      ex_mem.rd_addr    <= id_ex.rd_addr;
      ex_mem.rd_we      <= id_ex.rd_we;
      ex_mem.halt       <= id_ex.halt;
      ex_mem.trap       <= id_ex.trap;
    end
  end

endmodule : execute_stage

/* reg_file.sv */
// ****************************
// Register file with write
// before read bypass
// ****************************
module reg_file #(
  parameter  int NUM_READ_PORTS = 2,
  parameter  int NUM_REGS       = 32,
  localparam int RegAddrW       = $clog2(NUM_REGS)
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [RegAddrW-1:0]            i_rs_addr [NUM_READ_PORTS],
  output logic [core_pkg::DataWidth-1:0] o_rs_data [NUM_READ_PORTS],
  input  logic                           i_wr_en,
  input  logic [RegAddrW-1:0]            i_wr_addr,
  input  logic [core_pkg::DataWidth-1:0] i_wr_data
);

  logic [core_pkg::DataWidth-1:0] regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (i_wr_en && i_wr_addr != '0) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_READ_PORTS; p++) begin
      if (i_rs_addr[p] == '0) o_rs_data[p] = '0;  // x0 is hardwired
      else if (i_wr_en && i_wr_addr == i_rs_addr[p]) o_rs_data[p] = i_wr_data;
      else o_rs_data[p] = regs[i_rs_addr[p]];
    end
  end

endmodule : reg_file

/* decode_stage.sv */
// ****************************
// Instruction decode, hazard
// stall and ID/EX register
// ****************************
module decode_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [core_pkg::DataWidth-1:0]    i_instr,
  input  logic                              i_instr_valid,
  output logic [core_pkg::RegAddrWidth-1:0] o_rs_addr [2],
  input  logic [core_pkg::DataWidth-1:0]    i_rs_data [2],
  id_ex_if.producer                         id_ex,
  ex_mem_if.monitor                         ex_mem,
  output logic                              o_hold
);

  isa_pkg::opcode_e                  opcode;
  logic [2:0]                        funct3;
  logic [core_pkg::RegAddrWidth-1:0] rd;
  logic [core_pkg::DataWidth-1:0]    imm_i;
  logic [core_pkg::DataWidth-1:0]    imm_s;
  logic [core_pkg::DataWidth-1:0]    imm_u;
  isa_pkg::alu_op_e                  alu_f;  // From funct3 and bit 30
  isa_pkg::alu_op_e                  alu_op;
  isa_pkg::lsu_op_e                  lsu_op;
  logic [core_pkg::DataWidth-1:0]    operand_b;
  logic [1:0]                        use_rs;
  logic                              rd_we;
  logic                              halt;
  logic                              trap;
  logic                              hazard;

  function automatic logic clash(input logic valid, input logic we,
                                 input logic [core_pkg::RegAddrWidth-1:0] rd_addr,
                                 input logic [core_pkg::RegAddrWidth-1:0] rs_addr);
    return valid && we && (rd_addr == rs_addr);
  endfunction

  assign opcode       = isa_pkg::opcode_e'(i_instr[isa_pkg::OpcodeLsb +: isa_pkg::OpcodeWidth]);
  assign funct3       = i_instr[isa_pkg::Funct3Lsb +: 3];
  assign rd           = i_instr[isa_pkg::RdLsb +: core_pkg::RegAddrWidth];
  assign o_rs_addr[0] = i_instr[isa_pkg::Rs1Lsb +: core_pkg::RegAddrWidth];
  assign o_rs_addr[1] = i_instr[isa_pkg::Rs2Lsb +: core_pkg::RegAddrWidth];

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_u = {i_instr[31:12], 12'b0};

  always_comb begin
    unique case (funct3)
      3'b000: begin
        alu_f = (opcode == isa_pkg::OPC_OP && i_instr[isa_pkg::AltBit]) ? isa_pkg::ALU_SUB
                                                                       : isa_pkg::ALU_ADD;
      end
      3'b001: alu_f = isa_pkg::ALU_SLL;
      3'b010: alu_f = isa_pkg::ALU_SLT;
      3'b011: alu_f = isa_pkg::ALU_SLTU;
      3'b100: alu_f = isa_pkg::ALU_XOR;
      3'b101: alu_f = i_instr[isa_pkg::AltBit] ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      3'b110: alu_f = isa_pkg::ALU_OR;
      default: alu_f = isa_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    alu_op    = isa_pkg::ALU_ADD;  // Address add for loads and stores
    lsu_op    = isa_pkg::LSU_NONE;
    operand_b = imm_i;
    use_rs    = 2'b01;
    rd_we     = 1'b0;
    halt      = 1'b0;
    trap      = 1'b0;
    case (opcode)
      isa_pkg::OPC_OP: begin
        alu_op    = alu_f;
        operand_b = i_rs_data[1];
        use_rs    = 2'b11;
        rd_we     = 1'b1;
      end
      isa_pkg::OPC_OP_IMM: begin
        alu_op = alu_f;
        rd_we  = 1'b1;
      end
      isa_pkg::OPC_LUI: begin
        alu_op    = isa_pkg::ALU_PASS_B;
        operand_b = imm_u;
        use_rs    = 2'b00;
        rd_we     = 1'b1;
      end
      isa_pkg::OPC_LOAD: begin
        lsu_op = isa_pkg::LSU_LOAD;
        rd_we  = 1'b1;
      end
      isa_pkg::OPC_STORE: begin
        lsu_op    = isa_pkg::LSU_STORE;
        operand_b = imm_s;
        use_rs    = 2'b11;
      end
      isa_pkg::OPC_SYSTEM: begin
        use_rs = 2'b00;
        halt   = (i_instr[31:isa_pkg::RdLsb] == '0);  // ECALL only
        trap   = !halt;
      end
      default: begin
        use_rs = 2'b00;
        trap   = 1'b1;
      end
    endcase
  end

  // Source still being produced in EX or MEM
  always_comb begin
    hazard = 1'b0;
    for (int i = 0; i < 2; i++) begin
      hazard |= use_rs[i] && (clash(id_ex.valid, id_ex.rd_we, id_ex.rd_addr, o_rs_addr[i]) ||
                              clash(ex_mem.valid, ex_mem.rd_we, ex_mem.rd_addr, o_rs_addr[i]));
    end
    hazard &= i_instr_valid;
  end

  assign o_hold = hazard || ex_mem.stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else if (!ex_mem.stall) begin
      id_ex.valid <= i_instr_valid && !hazard;  // Bubble on hazard
    end
  end

  always_ff @(posedge clk) begin
    if (!ex_mem.stall) begin
      id_ex.alu_op     <= alu_op;
      id_ex.operand_a  <= i_rs_data[0];
      id_ex.operand_b  <= operand_b;
      id_ex.store_data <= i_rs_data[1];
      id_ex.lsu_op     <= lsu_op;
      id_ex.rd_addr    <= rd;
      id_ex.rd_we      <= rd_we && (rd != '0);
      id_ex.halt       <= halt;
      id_ex.trap       <= trap;
    end
  end

  // A held instruction stays in IF/ID
  a_hold_keeps_instr : assert property (@(posedge clk) disable iff (!rst_n)
    o_hold && i_instr_valid |=> i_instr_valid && $stable(i_instr));

endmodule : decode_stage

/* fetch_stage.sv */
// ****************************
// PC, instruction fetch request
// and IF/ID register
// ****************************
module fetch_stage #(
  parameter logic [core_pkg::AddrWidth-1:0] RESET_PC = core_pkg::ResetPcDefault
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           i_stall,        // Decode hold or memory stall
  input  logic                           i_halted,
  output logic                           o_imem_valid,
  output logic [core_pkg::AddrWidth-1:0] o_imem_addr,
  input  logic                           i_imem_ready,
  input  logic [core_pkg::DataWidth-1:0] i_imem_rdata,
  output logic [core_pkg::DataWidth-1:0] o_instr,
  output logic                           o_instr_valid
);

  logic [core_pkg::AddrWidth-1:0] pc_q;
  logic req_open_q;  // Request raised, no ready yet
  logic run_q;       // Low while in reset
  logic can_accept;
  logic handshake;

  // IF/ID is empty or drains this cycle
  assign can_accept   = !o_instr_valid || !i_stall;
  assign o_imem_valid = req_open_q || (run_q && !i_halted && can_accept);
  assign o_imem_addr  = pc_q;
  assign handshake    = o_imem_valid && i_imem_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= RESET_PC;
      req_open_q    <= 1'b0;
      run_q         <= 1'b0;
      o_instr_valid <= 1'b0;
    end else begin
      run_q      <= 1'b1;
      req_open_q <= o_imem_valid && !i_imem_ready;
      if (handshake) begin
        pc_q          <= pc_q + core_pkg::AddrWidth'(4);
        o_instr_valid <= 1'b1;
      end else if (!i_stall) begin
        o_instr_valid <= 1'b0;  // Consumed by decode
      end
    end
  end

  always_ff @(posedge clk) begin
    if (handshake) o_instr <= i_imem_rdata;
  end

  // An open request keeps its address until ready
  a_imem_stable : assert property (@(posedge clk) disable iff (!rst_n)
    o_imem_valid && !i_imem_ready |=> o_imem_valid && $stable(o_imem_addr));

endmodule : fetch_stage

/* pipe_ifs.sv */
// ****************************
// ID/EX and EX/MEM pipeline
// interfaces
// ****************************
interface id_ex_if;
  logic                              valid;
  isa_pkg::alu_op_e                  alu_op;
  logic [core_pkg::DataWidth-1:0]    operand_a;
  logic [core_pkg::DataWidth-1:0]    operand_b;   // rs2 or immediate
  logic [core_pkg::DataWidth-1:0]    store_data;
  isa_pkg::lsu_op_e                  lsu_op;
  logic [core_pkg::RegAddrWidth-1:0] rd_addr;
  logic                              rd_we;
  logic                              halt;
  logic                              trap;

  modport producer(output valid, alu_op, operand_a, operand_b, store_data, lsu_op,
                   rd_addr, rd_we, halt, trap);
  modport consumer(input valid, alu_op, operand_a, operand_b, store_data, lsu_op,
                   rd_addr, rd_we, halt, trap);
endinterface : id_ex_if

interface ex_mem_if;
  logic                              valid;
  logic [core_pkg::DataWidth-1:0]    result;      // ALU value or access address
  logic [core_pkg::DataWidth-1:0]    store_data;
  isa_pkg::lsu_op_e                  lsu_op;
  logic [core_pkg::RegAddrWidth-1:0] rd_addr;
  logic                              rd_we;
  logic                              halt;
  logic                              trap;
  logic                              stall;       // Data access waiting

  modport producer(output valid, result, store_data, lsu_op, rd_addr, rd_we, halt, trap,
                   input stall);
  modport consumer(input valid, result, store_data, lsu_op, rd_addr, rd_we, halt, trap,
                   output stall);
  modport monitor(input valid, rd_addr, rd_we, stall);
endinterface : ex_mem_if

/* isa_pkg.sv */
// ****************************
// RV32I opcodes, ALU and LSU
// operations, field positions
// ****************************
package isa_pkg;

  // Instruction field positions
  localparam int OpcodeLsb   = 0;
  localparam int OpcodeWidth = 7;
  localparam int RdLsb       = 7;
  localparam int Funct3Lsb   = 12;
  localparam int Rs1Lsb      = 15;
  localparam int Rs2Lsb      = 20;
  localparam int AltBit      = 30;  // Selects SUB and SRA

  typedef enum logic [OpcodeWidth-1:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B  // LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    LSU_NONE,
    LSU_LOAD,
    LSU_STORE
  } lsu_op_e;

endpackage : isa_pkg

/* core_pkg.sv */
// ****************************
// Core widths, register count
// and reset defaults
// ****************************
package core_pkg;

  localparam int DataWidth    = 32;  // Register and bus width
  localparam int AddrWidth    = 32;
  localparam int NumRegs      = 32;
  localparam int RegAddrWidth = 5;

  // Default for the top level RESET_PC
  localparam logic [AddrWidth-1:0] ResetPcDefault = '0;

endpackage : core_pkg
